// ==== include/fcore_defines.svh ====
// Shared widths, depths, address regions and register offsets for the fcore RTL and testbench
`ifndef FCORE_DEFINES_SVH
`define FCORE_DEFINES_SVH

// Data path and instruction word width
`define FCORE_DATA_WIDTH 32

// Program store depth in words
`define FCORE_PROG_DEPTH 256

// Channel count limit and registers per channel (the last register reads as the channel index)
`define FCORE_MAX_CHANNELS 8
`define FCORE_NUM_REGS 16

// Wishbone word address width; the top two bits select the region
`define FCORE_ADR_WIDTH 10
`define FCORE_REGION_PROG 2'd0
`define FCORE_REGION_REGS 2'd1
`define FCORE_REGION_CTRL 2'd2

// Offsets inside the control region
`define FCORE_CTRL_RUN 8'd0
`define FCORE_CTRL_SIZE 8'd1
`define FCORE_CTRL_NCH 8'd2
`define FCORE_CTRL_STATUS 8'd3

`endif

// ==== rtl/fcore_pkg.sv ====
// Opcode encoding and instruction word layouts shared by the fcore blocks and testbench
package fcore_pkg;

    // Opcode sits in the low five bits of every instruction word
    typedef enum logic [4:0] {
        NOP  = 5'd0,
        ADD  = 5'd1,
        SUB  = 5'd2,
        AND  = 5'd3,
        OR   = 5'd4,
        XOR  = 5'd5,
        LDI  = 5'd6,
        LDC  = 5'd7,
        STOP = 5'd8
    } opcode_t;

    // Register form: rd <= rs1 op rs2
    typedef struct packed {
        logic [14:0] pad;
        logic [3:0]  rs2;
        logic [3:0]  rs1;
        logic [3:0]  rd;
        opcode_t     opcode;
    } reg_form_t;

    // Immediate form: rd <= sign-extended imm
    typedef struct packed {
        logic [6:0]         pad;
        logic signed [15:0] imm;
        logic [3:0]         rd;
        opcode_t            opcode;
    } imm_form_t;

    // Both forms share opcode and rd, so either view may be used to read them
    typedef union packed {
        reg_form_t r;
        imm_form_t i;
    } instr_t;

endpackage

// ==== rtl/fcore_program_memory.sv ====
// Program store with a synchronous host port and an asynchronous two-word fetch port for the core
`timescale 1ns/10ps
`include "fcore_defines.svh"

module fcore_program_memory (
    input  logic                         clock,
    input  logic                         prog_we,
    input  logic [7:0]                   prog_addr,
    input  logic [`FCORE_DATA_WIDTH-1:0] prog_wdata,
    output logic [`FCORE_DATA_WIDTH-1:0] prog_rdata,
    input  logic [7:0]                   pc,
    output fcore_pkg::instr_t            fetch_word,
    output logic [`FCORE_DATA_WIDTH-1:0] fetch_next
);

    logic [`FCORE_DATA_WIDTH-1:0] mem [`FCORE_PROG_DEPTH];
    logic [7:0] pc_next;

    // Host side: write and read share the address, read data lands one cycle later
    always_ff @(posedge clock) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_wdata;
        end
        prog_rdata <= mem[prog_addr];
    end

    // The word after pc wraps to 0 at the end of the store
    assign pc_next = pc + 8'd1;

    // Fetch side is combinational so the control unit sees the current instruction
    // and the LDC constant in the same cycle
    assign fetch_word = mem[pc];
    assign fetch_next = mem[pc_next];

endmodule

// ==== rtl/fcore_control_unit.sv ====
// Run sequencer for the core: steps pc and channel, issues one instruction slot per cycle
`timescale 1ns/10ps
`include "fcore_defines.svh"

module fcore_control_unit (
    input  logic                         clock,
    input  logic                         rst_n,
    input  logic                         run,
    input  logic [8:0]                   program_size,
    input  logic [3:0]                   n_channels,
    input  fcore_pkg::instr_t            fetch_word,
    input  logic [`FCORE_DATA_WIDTH-1:0] fetch_next,
    output logic [7:0]                   pc,
    output logic                         issue_valid,
    output fcore_pkg::instr_t            issue_instr,
    output logic [`FCORE_DATA_WIDTH-1:0] issue_const,
    output logic [2:0]                   issue_channel,
    output logic                         busy,
    output logic                         done,
    output logic                         fault
);

    import fcore_pkg::*;

    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        WAIT    = 2'd1,
        RUNNING = 2'd2,
        FAULTED = 2'd3
    } state_t;

    state_t     state;
    logic [8:0] pc_count;
    logic [2:0] channel;
    logic [2:0] last_channel;
    logic       past_end;
    logic       is_stop;
    logic       is_ldc;
    logic       issue;

    // Zero channels runs as one, and anything above the limit is clamped
    always_comb begin
        if (n_channels == 4'd0) begin
            last_channel = 3'd0;
        end else if (n_channels > `FCORE_MAX_CHANNELS) begin
            last_channel = 3'(`FCORE_MAX_CHANNELS - 1);
        end else begin
            last_channel = 3'(n_channels - 4'd1);
        end
    end

    // pc is kept one bit wider than the store so running off the end is visible
    assign pc       = pc_count[7:0];
    assign past_end = pc_count >= program_size;
    assign is_stop  = fetch_word.r.opcode == STOP;
    assign is_ldc   = fetch_word.r.opcode == LDC;
    assign issue    = (state == RUNNING) && !past_end && !is_stop;
    assign busy     = (state == WAIT) || (state == RUNNING);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state       <= IDLE;
            pc_count    <= '0;
            channel     <= '0;
            issue_valid <= 1'b0;
            done        <= 1'b0;
            fault       <= 1'b0;
        end else begin
            issue_valid <= issue;
            case (state)
                IDLE, FAULTED: begin
                    if (run) begin
                        pc_count <= '0;
                        channel  <= '0;
                        done     <= 1'b0;
                        fault    <= 1'b0;
                        state    <= WAIT;
                    end
                end
                WAIT: begin
                    state <= RUNNING;
                end
                RUNNING: begin
                    // The pc check comes first, so nothing at or beyond the size is issued
                    if (past_end) begin
                        fault <= 1'b1;
                        state <= FAULTED;
                    end else if (is_stop) begin
                        done  <= 1'b1;
                        state <= IDLE;
                    end else if (channel == last_channel) begin
                        channel  <= '0;
                        // LDC steps over its constant word
                        pc_count <= pc_count + (is_ldc ? 9'd2 : 9'd1);
                    end else begin
                        channel <= channel + 3'd1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Slot payload only matters while issue_valid is high
    always_ff @(posedge clock) begin
        if (issue) begin
            issue_instr   <= fetch_word;
            issue_const   <= fetch_next;
            issue_channel <= channel;
        end
    end

endmodule

// ==== rtl/fcore_execution_unit.sv ====
// Per-channel register file and ALU that executes the slots issued by the control unit
`timescale 1ns/10ps
`include "fcore_defines.svh"

module fcore_execution_unit (
    input  logic                         clock,
    input  logic                         rst_n,
    input  logic                         issue_valid,
    input  fcore_pkg::instr_t            issue_instr,
    input  logic [`FCORE_DATA_WIDTH-1:0] issue_const,
    input  logic [2:0]                   issue_channel,
    input  logic [2:0]                   reg_channel,
    input  logic [3:0]                   reg_index,
    output logic [`FCORE_DATA_WIDTH-1:0] reg_rdata
);

    import fcore_pkg::*;

    localparam int DW      = `FCORE_DATA_WIDTH;
    localparam int NWR     = `FCORE_NUM_REGS - 1;
    localparam int CH_REG  = `FCORE_NUM_REGS - 1;

    // Register 15 is not stored, it always reads back as the channel index
    logic [DW-1:0] rf [`FCORE_MAX_CHANNELS][NWR];

    opcode_t       opcode;
    logic [3:0]    rd;
    logic [3:0]    rs1;
    logic [3:0]    rs2;
    logic [DW-1:0] chan_word;
    logic [DW-1:0] op_a;
    logic [DW-1:0] op_b;
    logic [DW-1:0] result;
    logic          writes;
    logic          wr_en;

    assign opcode    = issue_instr.r.opcode;
    assign rd        = issue_instr.r.rd;
    assign rs1       = issue_instr.r.rs1;
    assign rs2       = issue_instr.r.rs2;
    assign chan_word = {{(DW - 3){1'b0}}, issue_channel};

    assign op_a = (rs1 == 4'(CH_REG)) ? chan_word : rf[issue_channel][rs1];
    assign op_b = (rs2 == 4'(CH_REG)) ? chan_word : rf[issue_channel][rs2];

    always_comb begin
        writes = 1'b1;
        result = '0;
        case (opcode)
            ADD: result = op_a + op_b;
            SUB: result = op_a - op_b;
            AND: result = op_a & op_b;
            OR:  result = op_a | op_b;
            XOR: result = op_a ^ op_b;
            // Same word viewed through the immediate layout
            LDI: result = {{(DW - 16){issue_instr.i.imm[15]}}, issue_instr.i.imm};
            LDC: result = issue_const;
            default: writes = 1'b0;
        endcase
    end

    // Writes to the channel register are dropped
    assign wr_en = issue_valid && writes && (rd != 4'(CH_REG));

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int c = 0; c < `FCORE_MAX_CHANNELS; c++) begin
                for (int r = 0; r < NWR; r++) begin
                    rf[c][r] <= '0;
                end
            end
        end else if (wr_en) begin
            rf[issue_channel][rd] <= result;
        end
    end

    // Host read port, one cycle of latency to line up with the bus ack
    always_ff @(posedge clock) begin
        if (reg_index == 4'(CH_REG)) begin
            reg_rdata <= {{(DW - 3){1'b0}}, reg_channel};
        end else begin
            reg_rdata <= rf[reg_channel][reg_index];
        end
    end

endmodule

// ==== rtl/fcore_bus_regs.sv ====
// Wishbone classic slave: region decode, control and status registers and read data mux
`timescale 1ns/10ps
`include "fcore_defines.svh"

module fcore_bus_regs (
    input  logic                         clock,
    input  logic                         rst_n,
    input  logic                         cyc,
    input  logic                         stb,
    input  logic                         we,
    input  logic [`FCORE_ADR_WIDTH-1:0]  adr,
    input  logic [`FCORE_DATA_WIDTH-1:0] dat_w,
    output logic [`FCORE_DATA_WIDTH-1:0] dat_r,
    output logic                         ack,
    output logic                         prog_we,
    output logic [7:0]                   prog_addr,
    output logic [`FCORE_DATA_WIDTH-1:0] prog_wdata,
    input  logic [`FCORE_DATA_WIDTH-1:0] prog_rdata,
    output logic [2:0]                   reg_channel,
    output logic [3:0]                   reg_index,
    input  logic [`FCORE_DATA_WIDTH-1:0] reg_rdata,
    output logic                         run,
    output logic [8:0]                   program_size,
    output logic [3:0]                   n_channels,
    input  logic                         busy,
    input  logic                         done,
    input  logic                         fault
);

    logic [1:0] region;
    logic [7:0] offset;
    logic       access;
    logic       ctrl_write;

    assign region = adr[`FCORE_ADR_WIDTH-1 -: 2];
    assign offset = adr[7:0];

    // An access is the request cycle; the ack cycle that follows never starts another
    assign access     = cyc && stb && !ack;
    assign ctrl_write = access && we && (region == `FCORE_REGION_CTRL);

    assign prog_we     = access && we && (region == `FCORE_REGION_PROG);
    assign prog_addr   = adr[7:0];
    assign prog_wdata  = dat_w;
    assign reg_channel = adr[6:4];
    assign reg_index   = adr[3:0];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ack          <= 1'b0;
            run          <= 1'b0;
            program_size <= '0;
            n_channels   <= '0;
        end else begin
            ack <= access;
            run <= ctrl_write && (offset == `FCORE_CTRL_RUN) && dat_w[0];
            if (ctrl_write && offset == `FCORE_CTRL_SIZE) begin
                program_size <= dat_w[8:0];
            end
            if (ctrl_write && offset == `FCORE_CTRL_NCH) begin
                n_channels <= dat_w[3:0];
            end
        end
    end

    // Memory and register reads are already registered, so the mux is valid at ack
    always_comb begin
        dat_r = '0;
        case (region)
            `FCORE_REGION_PROG: dat_r = prog_rdata;
            `FCORE_REGION_REGS: dat_r = reg_rdata;
            `FCORE_REGION_CTRL: begin
                case (offset)
                    `FCORE_CTRL_SIZE:   dat_r[8:0] = program_size;
                    `FCORE_CTRL_NCH:    dat_r[3:0] = n_channels;
                    `FCORE_CTRL_STATUS: dat_r[2:0] = {fault, done, busy};
                    default:            dat_r = '0;
                endcase
            end
            default: dat_r = '0;
        endcase
    end

endmodule

// ==== rtl/fcore_top.sv ====
// Core top level joining the Wishbone slave, program store, control unit and execution unit
`timescale 1ns/10ps
`include "fcore_defines.svh"

module fcore_top (
    input  logic                         clock,
    input  logic                         rst_n,
    input  logic                         cyc,
    input  logic                         stb,
    input  logic                         we,
    input  logic [`FCORE_ADR_WIDTH-1:0]  adr,
    input  logic [`FCORE_DATA_WIDTH-1:0] dat_w,
    output logic [`FCORE_DATA_WIDTH-1:0] dat_r,
    output logic                         ack
);

    import fcore_pkg::*;

    logic                         prog_we;
    logic [7:0]                   prog_addr;
    logic [`FCORE_DATA_WIDTH-1:0] prog_wdata;
    logic [`FCORE_DATA_WIDTH-1:0] prog_rdata;
    logic [2:0]                   reg_channel;
    logic [3:0]                   reg_index;
    logic [`FCORE_DATA_WIDTH-1:0] reg_rdata;
    logic                         run;
    logic [8:0]                   program_size;
    logic [3:0]                   n_channels;
    logic                         busy;
    logic                         done;
    logic                         fault;
    logic [7:0]                   pc;
    instr_t                       fetch_word;
    logic [`FCORE_DATA_WIDTH-1:0] fetch_next;
    logic                         issue_valid;
    instr_t                       issue_instr;
    logic [`FCORE_DATA_WIDTH-1:0] issue_const;
    logic [2:0]                   issue_channel;

    fcore_bus_regs i_bus_regs (
        .clock, .rst_n, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack,
        .prog_we, .prog_addr, .prog_wdata, .prog_rdata,
        .reg_channel, .reg_index, .reg_rdata,
        .run, .program_size, .n_channels, .busy, .done, .fault
    );

    fcore_program_memory i_program_memory (
        .clock, .prog_we, .prog_addr, .prog_wdata, .prog_rdata,
        .pc, .fetch_word, .fetch_next
    );

    fcore_control_unit i_control_unit (
        .clock, .rst_n, .run, .program_size, .n_channels,
        .fetch_word, .fetch_next, .pc,
        .issue_valid, .issue_instr, .issue_const, .issue_channel,
        .busy, .done, .fault
    );

    fcore_execution_unit i_execution_unit (
        .clock, .rst_n,
        .issue_valid, .issue_instr, .issue_const, .issue_channel,
        .reg_channel, .reg_index, .reg_rdata
    );

endmodule

// ==== sim/fcore_sva.sv ====
// Concurrent checks on the control unit and Wishbone slave outputs, bound into the core top level
`timescale 1ns/10ps

module fcore_sva (
    input logic       clock,
    input logic       rst_n,
    input logic       ack,
    input logic       issue_valid,
    input logic [2:0] issue_channel,
    input logic [3:0] n_channels,
    input logic       busy,
    input logic       done,
    input logic       fault
);

    int failures = 0;

    ack_single: assert property (@(posedge clock) disable iff (!rst_n) ack |=> !ack)
        else begin
            failures++;
            $error("ack stayed high for a second cycle");
        end

    issue_in_run: assert property (@(posedge clock) disable iff (!rst_n) issue_valid |-> busy)
        else begin
            failures++;
            $error("issue slot outside a run");
        end

    done_or_fault: assert property (@(posedge clock) disable iff (!rst_n) !(done && fault))
        else begin
            failures++;
            $error("done and fault both high");
        end

    // A channel count of 0 runs channel 0 alone
    channel_range: assert property (@(posedge clock) disable iff (!rst_n)
        issue_valid |-> ({1'b0, issue_channel} < n_channels || issue_channel == 3'd0))
        else begin
            failures++;
            $error("issue channel beyond the channel count");
        end

endmodule

// The top level carries the nets between the control unit and the bus slave
bind fcore_top fcore_sva i_sva (
    .clock, .rst_n, .ack, .issue_valid, .issue_channel, .n_channels, .busy, .done, .fault
);

// ==== sim/fcore_tb.sv ====
// Directed testbench for the fcore microcore; every run is checked against an ISA model
`timescale 1ns/10ps
`include "fcore_defines.svh"

module fcore_tb;

    import fcore_pkg::*;

    // About 2000 bus accesses of 2 cycles each cover all tests with the status polling
    localparam int CYCLE_LIMIT = 4 * 2 * 2000;

    logic                         clock;
    logic                         rst_n;
    logic                         cyc;
    logic                         stb;
    logic                         we;
    logic [`FCORE_ADR_WIDTH-1:0]  adr;
    logic [`FCORE_DATA_WIDTH-1:0] dat_w;
    logic [`FCORE_DATA_WIDTH-1:0] dat_r;
    logic                         ack;

    int          errors;
    int          checks;
    int          cycles;
    logic [31:0] lfsr;
    logic [31:0] rdata;
    logic [31:0] prog [$];
    logic [31:0] model [`FCORE_MAX_CHANNELS][`FCORE_NUM_REGS];

    fcore_top i_dut (.clock, .rst_n, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles because a test never finished", cycles);
            $display("tests failed");
            $finish;
        end
    end

    // Fields are packed from the low bits up as opcode, rd, then rs1 and rs2 or a 16-bit immediate
    function automatic logic [31:0] encode_reg(opcode_t op, int rd, int rs1, int rs2);
        return {15'd0, 4'(rs2), 4'(rs1), 4'(rd), op};
    endfunction

    function automatic logic [31:0] encode_imm(opcode_t op, int rd, int imm);
        return {7'd0, 16'(imm), 4'(rd), op};
    endfunction

    // Fibonacci LFSR with taps 32, 22, 2 and 1 that steps once for each bit taken
    function automatic logic [31:0] random_bits(int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int k = 0; k < n; k++) begin
            fb    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr  = {lfsr[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic logic [31:0] fill_word(int a);
        return (32'(a) * 32'h9e37_79b9) ^ {8'(a), 8'(~a), 16'h5ac3};
    endfunction

    // Each channel walks the program on its own registers; returns 1 when the run faults
    function automatic logic run_model(int nch);
        instr_t      w;
        int          pc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        wr;
        logic        stopped;
        stopped = 1'b0;
        for (int ch = 0; ch < ((nch == 0) ? 1 : nch); ch++) begin
            pc      = 0;
            stopped = 1'b0;
            while (!stopped && pc < prog.size()) begin
                w  = prog[pc];
                a  = (w.r.rs1 == 4'd15) ? 32'(ch) : model[ch][w.r.rs1];
                b  = (w.r.rs2 == 4'd15) ? 32'(ch) : model[ch][w.r.rs2];
                wr = 1'b1;
                case (w.r.opcode)
                    ADD: res = a + b;
                    SUB: res = a - b;
                    AND: res = a & b;
                    OR:  res = a | b;
                    XOR: res = a ^ b;
                    LDI: res = {{16{w.i.imm[15]}}, w.i.imm};
                    LDC: res = prog[pc + 1];
                    default: wr = 1'b0;
                endcase
                if (wr && w.r.rd != 4'd15) begin
                    model[ch][w.r.rd] = res;
                end
                stopped = (w.r.opcode == STOP);
                pc += (w.r.opcode == LDC) ? 2 : 1;
            end
        end
        return !stopped;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("** Error at %0t: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    // One Wishbone classic cycle that starts and ends on a falling edge
    task automatic wb_access(input logic write, input logic [9:0] addr,
                             input logic [31:0] wdata, output logic [31:0] data);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = write;
        adr   = addr;
        dat_w = wdata;
        @(negedge clock);
        while (!ack) begin
            @(negedge clock);
        end
        data = dat_r;
        cyc  = 1'b0;
        stb  = 1'b0;
        we   = 1'b0;
        @(negedge clock);
        check_value(32'(ack), 32'd0, $sformatf("ack one cycle after the ack at %h", addr));
    endtask

    task automatic load_program();
        for (int i = 0; i < prog.size(); i++) begin
            wb_access(1'b1, {`FCORE_REGION_PROG, 8'(i)}, prog[i], rdata);
        end
        wb_access(1'b1, {`FCORE_REGION_CTRL, `FCORE_CTRL_SIZE}, 32'(prog.size()), rdata);
    endtask

    task automatic start_and_wait(input int nch, input logic extra_run, output logic [2:0] status);
        wb_access(1'b1, {`FCORE_REGION_CTRL, `FCORE_CTRL_NCH}, 32'(nch), rdata);
        wb_access(1'b1, {`FCORE_REGION_CTRL, `FCORE_CTRL_RUN}, 32'd1, rdata);
        if (extra_run) begin
            // A second run pulse in the middle of the run must not restart it
            wb_access(1'b0, {`FCORE_REGION_CTRL, `FCORE_CTRL_STATUS}, 32'd0, rdata);
            check_value(32'(rdata[0]), 32'd1, "busy bit during run");
            wb_access(1'b1, {`FCORE_REGION_CTRL, `FCORE_CTRL_RUN}, 32'd1, rdata);
        end
        rdata = '0;
        while (rdata[2:1] == 2'b00) begin
            wb_access(1'b0, {`FCORE_REGION_CTRL, `FCORE_CTRL_STATUS}, 32'd0, rdata);
        end
        status = rdata[2:0];
    endtask

    task automatic check_reg(input int ch, input int idx);
        wb_access(1'b0, {`FCORE_REGION_REGS, 8'(ch * 16 + idx)}, 32'd0, rdata);
        check_value(rdata, (idx == 15) ? 32'(ch) : model[ch][idx],
                    $sformatf("channel %0d r%0d", ch, idx));
    endtask

    // Loads prog, runs it and compares status and every register of every channel
    task automatic run_program(input int nch, input logic extra_run);
        logic       faulted;
        logic [2:0] status;
        load_program();
        faulted = run_model(nch);
        start_and_wait(nch, extra_run, status);
        check_value(32'(status), faulted ? 32'd4 : 32'd2, "STATUS after run");
        for (int ch = 0; ch < `FCORE_MAX_CHANNELS; ch++) begin
            for (int idx = 0; idx < `FCORE_NUM_REGS; idx++) begin
                check_reg(ch, idx);
            end
        end
    endtask

    task automatic memory_readback();
        for (int a = 0; a < `FCORE_PROG_DEPTH; a++) begin
            wb_access(1'b1, {`FCORE_REGION_PROG, 8'(a)}, fill_word(a), rdata);
        end
        for (int a = 0; a < `FCORE_PROG_DEPTH; a++) begin
            wb_access(1'b0, {`FCORE_REGION_PROG, 8'(a)}, 32'd0, rdata);
            check_value(rdata, fill_word(a), $sformatf("program word %0d", a));
        end
    endtask

    task automatic alu_program();
        prog = '{encode_imm(LDI, 1, 100), encode_imm(LDI, 2, -7),
                 encode_reg(ADD, 3, 1, 15), encode_reg(SUB, 4, 2, 15),
                 encode_reg(AND, 5, 3, 4), encode_reg(OR, 6, 3, 2),
                 encode_reg(XOR, 7, 6, 15), encode_reg(ADD, 15, 1, 1),
                 encode_reg(SUB, 8, 15, 1), encode_imm(STOP, 0, 0)};
        run_program(4, 1'b0);
    endtask

    // Constant words whose opcode field reads as STOP and as ADD
    task automatic ldc_skip();
        prog = '{encode_imm(LDC, 1, 0), 32'habcd_0008, encode_imm(LDC, 2, 0), 32'h1234_5661,
                 encode_reg(XOR, 3, 1, 2), encode_reg(ADD, 4, 3, 15), encode_imm(STOP, 0, 0)};
        run_program(3, 1'b0);
    endtask

    // The program accumulates, so a restarted run would show up in the results
    task automatic stop_and_channels();
        prog.delete();
        for (int k = 0; k < 6; k++) begin
            prog.push_back(encode_reg(ADD, 9, 9, 15));
            prog.push_back(encode_reg(ADD, 10, 10, 9));
            prog.push_back(encode_reg(XOR, 11, 11, 10));
        end
        prog.push_back(encode_imm(STOP, 0, 0));
        run_program(1, 1'b0);
        run_program(8, 1'b1);
    endtask

    task automatic fault_recovery();
        prog = '{encode_imm(LDI, 12, 5), encode_reg(ADD, 12, 12, 15),
                 encode_reg(ADD, 13, 12, 12)};
        run_program(2, 1'b0);
        prog.push_back(encode_imm(STOP, 0, 0));
        run_program(2, 1'b0);
    endtask

    task automatic random_alu();
        int op;
        int rd;
        int rs1;
        int rs2;
        prog.delete();
        for (int k = 1; k <= 4; k++) begin
            prog.push_back(encode_imm(LDC, k, 0));
            prog.push_back(random_bits(32));
        end
        for (int k = 0; k < 12; k++) begin
            op  = int'(ADD) + int'(random_bits(3) % 5);
            rd  = int'(random_bits(4));
            rs1 = int'(random_bits(4));
            rs2 = int'(random_bits(4));
            prog.push_back(encode_reg(opcode_t'(op), rd, rs1, rs2));
        end
        prog.push_back(encode_imm(STOP, 0, 0));
        run_program(1 + int'(random_bits(3)), 1'b0);
    endtask

    initial begin
        errors = 0;
        checks = 0;
        cycles = 0;
        lfsr   = 32'h0c21cb55;
        rst_n  = 1'b0;
        cyc    = 1'b0;
        stb    = 1'b0;
        we     = 1'b0;
        adr    = '0;
        dat_w  = '0;
        // Register files come out of reset cleared
        for (int ch = 0; ch < `FCORE_MAX_CHANNELS; ch++) begin
            for (int idx = 0; idx < `FCORE_NUM_REGS; idx++) begin
                model[ch][idx] = '0;
            end
        end
        repeat (3) @(negedge clock);
        rst_n = 1'b1;
        memory_readback();
        alu_program();
        ldc_skip();
        stop_and_channels();
        fault_recovery();
        random_alu();
        errors = errors + i_dut.i_sva.failures;
        $display("Finished %0d checks with %0d errors", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+include
rtl/fcore_pkg.sv
rtl/fcore_program_memory.sv
rtl/fcore_control_unit.sv
rtl/fcore_execution_unit.sv
rtl/fcore_bus_regs.sv
rtl/fcore_top.sv
sim/fcore_sva.sv
sim/fcore_tb.sv

// ==== Bender.yml ====
package:
  name: fcore

export_include_dirs:
  - include

sources:
  - files:
      - rtl/fcore_pkg.sv
      - rtl/fcore_program_memory.sv
      - rtl/fcore_control_unit.sv
      - rtl/fcore_execution_unit.sv
      - rtl/fcore_bus_regs.sv
      - rtl/fcore_top.sv
  - target: simulation
    files:
      - sim/fcore_sva.sv
      - sim/fcore_tb.sv
